// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       = rcc_rst_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Verification failed
PASS_MSG  = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/rcc_domain_rst_seq.sv
`timescale 1ns/1ns
`default_nettype none

module rcc_domain_rst_seq #(
  parameter int DURATION = 10
) (
  input  wire  sys_clk_pre,
  input  wire  pwr_d1_ok,
  input  wire  sys_rst_n,
  input  wire  release_ok,
  output logic dom_rst_n
);

  localparam int CNT_W = $clog2(DURATION + 1);

  logic [CNT_W-1:0] rel_cnt;
  logic             cnt_done;

  assign cnt_done = (rel_cnt == CNT_W'(DURATION));

  ////////////////////////////////////////////////////////////////////////////
  // counted domain release
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk_pre or negedge pwr_d1_ok) begin
    if (!pwr_d1_ok) begin
      rel_cnt   <= '0;
      dom_rst_n <= 1'b0;
    end else if (!sys_rst_n) begin
      // system in reset, start over
      rel_cnt   <= '0;
      dom_rst_n <= 1'b0;
    end else if (!cnt_done) begin
      rel_cnt   <= rel_cnt + 1'b1;
      dom_rst_n <= 1'b0;
    end else if (release_ok) begin
      // count saturated, only the release condition left
      dom_rst_n <= 1'b1;
    end
  end

  a_no_early_release : assert property (@(posedge sys_clk_pre) disable iff (!pwr_d1_ok)
    !sys_rst_n |=> !dom_rst_n)
    else $error("domain reset released while system reset low");

endmodule

`default_nettype wire

// File: design/rcc_rst_pkg.sv
`default_nettype none

`include "rcc_rst_defs.svh"

package rcc_rst_pkg;

  // one bit per reset cause, por in bit 0 up to sft2
  typedef logic [`RCC_NUM_SRC-1:0] rst_src_t;

  // software peripheral reset vector
  typedef logic [`RCC_NUM_PER-1:0] per_rst_t;

  // wishbone word address and data
  typedef logic [3:0]  wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // system reset fsm
  typedef enum logic [1:0] {
    SYS_HOLD,
    SYS_WAIT_REL,
    SYS_RUN
  } sys_rst_state_t;

endpackage

`default_nettype wire

// File: design/rcc_rst_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "rcc_rst_defs.svh"

module rcc_rst_regs (
  input  wire                   sys_clk_pre,
  input  wire                   pwr_d1_ok,
  input  wire rcc_rst_pkg::rst_src_t src_sync,
  input  wire                   sys_rst_n,
  input  wire                   d1_rst_n,
  input  wire                   d2_rst_n,
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire rcc_rst_pkg::wb_adr_t  wb_adr,
  input  wire rcc_rst_pkg::wb_dat_t  wb_dat_w,
  output rcc_rst_pkg::wb_dat_t  wb_dat_r,
  output logic                  wb_ack,
  output logic                  cpu1_rst_n,
  output logic                  cpu2_rst_n,
  output rcc_rst_pkg::per_rst_t per_rst_n
);
  import rcc_rst_pkg::*;

  logic     wb_req;
  logic     wr_en;
  logic     rmvf_wr;
  logic     prstr_wr;
  rst_src_t flags;
  per_rst_t prstr;
  wb_dat_t  rd_mux;

  // new request only while no ack is out
  assign wb_req   = wb_cyc & wb_stb & ~wb_ack;
  assign wr_en    = wb_req & wb_we;
  assign rmvf_wr  = wr_en & (wb_adr == wb_adr_t'(`RCC_ADR_RSR)) & wb_dat_w[`RCC_RMVF_BIT];
  assign prstr_wr = wr_en & (wb_adr == wb_adr_t'(`RCC_ADR_PRSTR));

  ////////////////////////////////////////////////////////////////////////////
  // wishbone handshake and read mux
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk_pre or negedge pwr_d1_ok) begin
    if (!pwr_d1_ok) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      wb_adr_t'(`RCC_ADR_RSR):   rd_mux[`RCC_NUM_SRC-1:0] = flags;
      wb_adr_t'(`RCC_ADR_PRSTR): rd_mux[`RCC_NUM_PER-1:0] = prstr;
      default:                   rd_mux = '0;
    endcase
  end

  // read data lands with the ack
  always_ff @(posedge sys_clk_pre) begin
    if (wb_req) begin
      wb_dat_r <= rd_mux;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // cause flags, peripheral resets, cpu resets
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk_pre or negedge pwr_d1_ok) begin
    if (!pwr_d1_ok) begin
      flags      <= '0;
      prstr      <= '0;
      cpu1_rst_n <= 1'b0;
      cpu2_rst_n <= 1'b0;
      per_rst_n  <= '0;
    end else begin
      // sticky, survives sys reset, live source sets again next cycle
      if (rmvf_wr) begin
        flags <= '0;
      end else begin
        flags <= flags | src_sync;
      end
      if (!sys_rst_n) begin
        prstr <= '0;
      end else if (prstr_wr) begin
        prstr <= wb_dat_w[`RCC_NUM_PER-1:0];
      end
      // window watchdog always resets its own cpu
      cpu1_rst_n <= sys_rst_n & d1_rst_n & ~src_sync[`RCC_SRC_WWDG1];
      cpu2_rst_n <= sys_rst_n & d2_rst_n & ~src_sync[`RCC_SRC_WWDG2];
      per_rst_n  <= ~prstr;
    end
  end

  a_single_ack : assert property (@(posedge sys_clk_pre) disable iff (!pwr_d1_ok)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for two cycles");

endmodule

`default_nettype wire

// File: design/rcc_rst_src_sync.sv
`timescale 1ns/1ns
`default_nettype none

`include "rcc_rst_defs.svh"

module rcc_rst_src_sync (
  input  wire                  sys_clk_pre,
  input  wire                  pwr_d1_ok,
  input  wire                  pwr_por_rst,
  input  wire                  pwr_bor_rst,
  input  wire                  nrst_in,
  input  wire                  iwdg1_out_rst,
  input  wire                  wwdg1_out_rst,
  input  wire                  iwdg2_out_rst,
  input  wire                  wwdg2_out_rst,
  input  wire                  lpwr1_rst,
  input  wire                  lpwr2_rst,
  input  wire                  cpu1_sftrst,
  input  wire                  cpu2_sftrst,
  input  wire                  ww1rsc,
  input  wire                  ww2rsc,
  output rcc_rst_pkg::rst_src_t src_sync,
  output logic                 src_active,
  output logic                 nrst_out
);
  import rcc_rst_pkg::*;

  rst_src_t raw_src;
  rst_src_t sync_q1;
  rst_src_t cause_en;
  logic     active_nxt;

  // gather the sources, pin made active high
  always_comb begin
    raw_src[`RCC_SRC_POR]   = pwr_por_rst;
    raw_src[`RCC_SRC_BOR]   = pwr_bor_rst;
    raw_src[`RCC_SRC_PIN]   = ~nrst_in;
    raw_src[`RCC_SRC_IWDG1] = iwdg1_out_rst;
    raw_src[`RCC_SRC_WWDG1] = wwdg1_out_rst;
    raw_src[`RCC_SRC_IWDG2] = iwdg2_out_rst;
    raw_src[`RCC_SRC_WWDG2] = wwdg2_out_rst;
    raw_src[`RCC_SRC_LPWR1] = lpwr1_rst;
    raw_src[`RCC_SRC_LPWR2] = lpwr2_rst;
    raw_src[`RCC_SRC_SFT1]  = cpu1_sftrst;
    raw_src[`RCC_SRC_SFT2]  = cpu2_sftrst;
  end

  // window watchdogs only reset the system when enabled
  always_comb begin
    cause_en                = '1;
    cause_en[`RCC_SRC_WWDG1] = ww1rsc;
    cause_en[`RCC_SRC_WWDG2] = ww2rsc;
    active_nxt              = |(sync_q1 & cause_en);
  end

  ////////////////////////////////////////////////////////////////////////////
  // two-flop synchronizer, active flag and pin drive share the second stage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk_pre or negedge pwr_d1_ok) begin
    if (!pwr_d1_ok) begin
      sync_q1    <= '0;
      src_sync   <= '0;
      src_active <= 1'b0;
      nrst_out   <= 1'b0;
    end else begin
      sync_q1    <= raw_src;
      src_sync   <= sync_q1;
      src_active <= active_nxt;
      // pin pulled low for as long as a cause is active
      nrst_out   <= ~active_nxt;
    end
  end

  a_pin_follows_cause : assert property (@(posedge sys_clk_pre) disable iff (!pwr_d1_ok)
    src_active |-> !nrst_out)
    else $error("nrst_out high while a reset cause is active");

endmodule

`default_nettype wire

// File: design/rcc_sys_rst_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rcc_sys_rst_gen (
  input  wire  sys_clk_pre,
  input  wire  pwr_d1_ok,
  input  wire  src_active,
  input  wire  pwr_por_rst,
  input  wire  pwr_vcore_ok,
  input  wire  flash_obl_reload,
  input  wire  obl_done,
  input  wire  hsi_rdy,
  input  wire  flash_power_ok,
  output logic sys_rst_n,
  output logic stby_rst_n
);
  import rcc_rst_pkg::*;

  logic           obl_rst;
  logic           hw_init_done;
  logic           sys_hold_req;
  sys_rst_state_t state;
  sys_rst_state_t state_nxt;

  // option bytes still loading or being reloaded
  assign obl_rst      = ~obl_done | flash_obl_reload;
  assign hw_init_done = ~pwr_por_rst & pwr_vcore_ok & ~obl_rst;
  // any reason to pull the system back into reset
  assign sys_hold_req = src_active | ~hw_init_done;

  ////////////////////////////////////////////////////////////////////////////
  // system reset fsm
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    if (sys_hold_req) begin
      state_nxt = SYS_HOLD;
    end else begin
      case (state)
        // causes gone, wait for clock and flash
        SYS_HOLD:     state_nxt = SYS_WAIT_REL;
        SYS_WAIT_REL: begin
          if (hsi_rdy && flash_power_ok) begin
            state_nxt = SYS_RUN;
          end
        end
        SYS_RUN:      state_nxt = SYS_RUN;
        default:      state_nxt = SYS_HOLD;
      endcase
    end
  end

  always_ff @(posedge sys_clk_pre or negedge pwr_d1_ok) begin
    if (!pwr_d1_ok) begin
      state      <= SYS_HOLD;
      sys_rst_n  <= 1'b0;
      stby_rst_n <= 1'b0;
    end else begin
      state      <= state_nxt;
      // released together with the move into run
      sys_rst_n  <= (state_nxt == SYS_RUN);
      // standby domain only needs vcore, no por and loaded option bytes
      stby_rst_n <= ~(pwr_por_rst | ~pwr_vcore_ok | ~obl_done);
    end
  end

  a_hold_in_reset : assert property (@(posedge sys_clk_pre) disable iff (!pwr_d1_ok)
    (state == SYS_HOLD) |-> !sys_rst_n)
    else $error("sys_rst_n high in SYS_HOLD");

  a_stby_on_vcore : assert property (@(posedge sys_clk_pre) disable iff (!pwr_d1_ok)
    !pwr_vcore_ok |=> !stby_rst_n)
    else $error("stby_rst_n high after vcore loss");

endmodule

`default_nettype wire

// File: design/rcc_vcore_rst_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "rcc_rst_defs.svh"

module rcc_vcore_rst_ctrl (
  input  wire                        sys_clk_pre,
  input  wire                        pwr_d1_ok,
  input  wire                        pwr_d2_ok,
  input  wire                        pwr_por_rst,
  input  wire                        pwr_bor_rst,
  input  wire                        pwr_vcore_ok,
  input  wire                        nrst_in,
  input  wire                        iwdg1_out_rst,
  input  wire                        wwdg1_out_rst,
  input  wire                        iwdg2_out_rst,
  input  wire                        wwdg2_out_rst,
  input  wire                        lpwr1_rst,
  input  wire                        lpwr2_rst,
  input  wire                        cpu1_sftrst,
  input  wire                        cpu2_sftrst,
  input  wire                        ww1rsc,
  input  wire                        ww2rsc,
  input  wire                        flash_obl_reload,
  input  wire                        obl_done,
  input  wire                        hsi_rdy,
  input  wire                        flash_power_ok,
  input  wire                        wb_cyc,
  input  wire                        wb_stb,
  input  wire                        wb_we,
  input  wire rcc_rst_pkg::wb_adr_t  wb_adr,
  input  wire rcc_rst_pkg::wb_dat_t  wb_dat_w,
  output wire rcc_rst_pkg::wb_dat_t  wb_dat_r,
  output wire                        wb_ack,
  output wire                        sys_rst_n,
  output wire                        d1_rst_n,
  output wire                        d2_rst_n,
  output wire                        stby_rst_n,
  output wire                        nrst_out,
  output wire                        cpu1_rst_n,
  output wire                        cpu2_rst_n,
  output wire rcc_rst_pkg::per_rst_t per_rst_n
);
  import rcc_rst_pkg::*;

  rst_src_t src_sync;
  logic     src_active;

  ////////////////////////////////////////////////////////////////////////////
  // source sync, then system reset
  ////////////////////////////////////////////////////////////////////////////
  rcc_rst_src_sync u_src_sync (
    .sys_clk_pre   (sys_clk_pre),
    .pwr_d1_ok     (pwr_d1_ok),
    .pwr_por_rst   (pwr_por_rst),
    .pwr_bor_rst   (pwr_bor_rst),
    .nrst_in       (nrst_in),
    .iwdg1_out_rst (iwdg1_out_rst),
    .wwdg1_out_rst (wwdg1_out_rst),
    .iwdg2_out_rst (iwdg2_out_rst),
    .wwdg2_out_rst (wwdg2_out_rst),
    .lpwr1_rst     (lpwr1_rst),
    .lpwr2_rst     (lpwr2_rst),
    .cpu1_sftrst   (cpu1_sftrst),
    .cpu2_sftrst   (cpu2_sftrst),
    .ww1rsc        (ww1rsc),
    .ww2rsc        (ww2rsc),
    .src_sync      (src_sync),
    .src_active    (src_active),
    .nrst_out      (nrst_out)
  );

  rcc_sys_rst_gen u_sys_rst_gen (
    .sys_clk_pre      (sys_clk_pre),
    .pwr_d1_ok        (pwr_d1_ok),
    .src_active       (src_active),
    .pwr_por_rst      (pwr_por_rst),
    .pwr_vcore_ok     (pwr_vcore_ok),
    .flash_obl_reload (flash_obl_reload),
    .obl_done         (obl_done),
    .hsi_rdy          (hsi_rdy),
    .flash_power_ok   (flash_power_ok),
    .sys_rst_n        (sys_rst_n),
    .stby_rst_n       (stby_rst_n)
  );

  // d1 waits on flash power, d2 on its own supply
  rcc_domain_rst_seq #(.DURATION(`RCC_D1_RST_CYCLES)) u_d1_rst_seq (
    .sys_clk_pre (sys_clk_pre),
    .pwr_d1_ok   (pwr_d1_ok),
    .sys_rst_n   (sys_rst_n),
    .release_ok  (flash_power_ok),
    .dom_rst_n   (d1_rst_n)
  );

  rcc_domain_rst_seq #(.DURATION(`RCC_D2_RST_CYCLES)) u_d2_rst_seq (
    .sys_clk_pre (sys_clk_pre),
    .pwr_d1_ok   (pwr_d1_ok),
    .sys_rst_n   (sys_rst_n),
    .release_ok  (pwr_d2_ok),
    .dom_rst_n   (d2_rst_n)
  );

  ////////////////////////////////////////////////////////////////////////////
  // register stage
  ////////////////////////////////////////////////////////////////////////////
  rcc_rst_regs u_rst_regs (
    .sys_clk_pre (sys_clk_pre),
    .pwr_d1_ok   (pwr_d1_ok),
    .src_sync    (src_sync),
    .sys_rst_n   (sys_rst_n),
    .d1_rst_n    (d1_rst_n),
    .d2_rst_n    (d2_rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .cpu1_rst_n  (cpu1_rst_n),
    .cpu2_rst_n  (cpu2_rst_n),
    .per_rst_n   (per_rst_n)
  );

endmodule

`default_nettype wire

// File: include/rcc_rst_defs.svh
`ifndef RCC_RST_DEFS_SVH
`define RCC_RST_DEFS_SVH

// domain release counts, in sys_clk_pre cycles
`define RCC_D1_RST_CYCLES 10
`define RCC_D2_RST_CYCLES 12

// software peripheral resets
`define RCC_NUM_PER 8

// reset cause vector, one bit per source
`define RCC_NUM_SRC   11
`define RCC_SRC_POR   0
`define RCC_SRC_BOR   1
`define RCC_SRC_PIN   2
`define RCC_SRC_IWDG1 3
`define RCC_SRC_WWDG1 4
`define RCC_SRC_IWDG2 5
`define RCC_SRC_WWDG2 6
`define RCC_SRC_LPWR1 7
`define RCC_SRC_LPWR2 8
`define RCC_SRC_SFT1  9
`define RCC_SRC_SFT2  10

// wishbone word addresses
`define RCC_ADR_RSR   0
`define RCC_ADR_PRSTR 1

// rsr write bit that clears the cause flags
`define RCC_RMVF_BIT 16

`endif

// File: sim/rcc_rst_stim.txt
# op args: set <inputs hex> | pulse <cause hex> <drop hex> | wait <out> <limit> | hold <out> <lvl> <n>
# wr <adr> <data hex> | wrr <adr> | rd <adr> <hex or m> | test <name>
test power_up
set 2f
wait sys 20
wait d1 40
wait d2 40
wait cpu1 10
wait cpu2 10
rd 0 0
rd 1 0
test cause_capture
pulse 2 f
wait cpu2 60
pulse 4 f
wait cpu2 60
pulse 8 f
wait cpu2 60
pulse 100 f
wait cpu2 60
pulse 200 f
wait cpu2 60
rd 0 30e
test wwdg_enable
pulse 10 4
wait cpu1 20
set 6f
pulse 10 f
wait cpu2 60
set 2f
rd 0 m
test flag_clear
wr 0 10000
hold sys 1 4
rd 0 0
test periph_reset
wrr 1
rd 1 m
wrr 1
rd 1 m
wrr 1
rd 1 m
pulse 2 f
wait cpu2 60
rd 1 0
test standby_init
set 2b
hold stby 0 3
hold sys 0 3
set 2f
wait stby 10
wait cpu2 60
set 3f
hold sys 0 10
set 2f
wait sys 20
wait cpu2 60

// File: sim/rcc_rst_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rcc_rst_defs.svh"

module rcc_rst_tb;
  import rcc_rst_pkg::*;

  // stim waits add up to well under this
  localparam int MAX_CYCLES = 4000;
  localparam int ACK_LIMIT  = 16;

  logic     sys_clk_pre;
  logic     pwr_d1_ok, pwr_d2_ok, pwr_por_rst, pwr_bor_rst, pwr_vcore_ok;
  logic     nrst_in, iwdg1_out_rst, wwdg1_out_rst, iwdg2_out_rst, wwdg2_out_rst;
  logic     lpwr1_rst, lpwr2_rst, cpu1_sftrst, cpu2_sftrst, ww1rsc, ww2rsc;
  logic     flash_obl_reload, obl_done, hsi_rdy, flash_power_ok;
  logic     wb_cyc, wb_stb, wb_we, wb_ack;
  wb_adr_t  wb_adr;
  wb_dat_t  wb_dat_w;
  wb_dat_t  wb_dat_r;
  logic     sys_rst_n, d1_rst_n, d2_rst_n, stby_rst_n, nrst_out, cpu1_rst_n, cpu2_rst_n;
  per_rst_t per_rst_n;

  // reference model state
  rst_src_t flag_model;
  per_rst_t prstr_model;
  int       cyc_cnt = 0;
  int       sys_rise_cyc;
  logic     sys_prev;
  int       test_err, err_total, pass_cnt, fail_cnt;
  string    test_name;

  rcc_vcore_rst_ctrl DUT (.*);

  always #50 sys_clk_pre = ~sys_clk_pre;

  always @(posedge sys_clk_pre) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  // run limit
  always @(negedge sys_clk_pre) begin
    if (cyc_cnt >= MAX_CYCLES) begin
      $display("simulation stopped after %0d cycles without finishing the stimulus", cyc_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bookkeeping
  ////////////////////////////////////////////////////////////////////////////
  task automatic flag_error(input string msg);
    $display("ERROR %0t ns: %s", $time, msg);
    test_err++;
    err_total++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    test_err++;
    err_total++;
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      if (test_err == 0) begin
        pass_cnt++;
        $display("test %s: ok", test_name);
      end else begin
        fail_cnt++;
        $display("test %s: %0d errors", test_name, test_err);
      end
    end
    test_name = "";
    test_err  = 0;
  endtask

  // one negedge, inputs change and outputs are sampled here
  task automatic step();
    @(negedge sys_clk_pre);
    if (sys_rst_n && !sys_prev) sys_rise_cyc = cyc_cnt;
    sys_prev = sys_rst_n;
    // prstr is wiped while the system sits in reset
    if (!sys_rst_n) prstr_model = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // input drive
  ////////////////////////////////////////////////////////////////////////////
  task automatic apply_static(input logic [7:0] v);
    hsi_rdy          = v[0];
    flash_power_ok   = v[1];
    pwr_vcore_ok     = v[2];
    obl_done         = v[3];
    flash_obl_reload = v[4];
    pwr_d2_ok        = v[5];
    ww1rsc           = v[6];
    ww2rsc           = v[7];
  endtask

  // cause vector onto the source pins, pin bit is active low on the wire
  task automatic apply_src(input rst_src_t s);
    pwr_por_rst   = s[`RCC_SRC_POR];
    pwr_bor_rst   = s[`RCC_SRC_BOR];
    nrst_in       = ~s[`RCC_SRC_PIN];
    iwdg1_out_rst = s[`RCC_SRC_IWDG1];
    wwdg1_out_rst = s[`RCC_SRC_WWDG1];
    iwdg2_out_rst = s[`RCC_SRC_IWDG2];
    wwdg2_out_rst = s[`RCC_SRC_WWDG2];
    lpwr1_rst     = s[`RCC_SRC_LPWR1];
    lpwr2_rst     = s[`RCC_SRC_LPWR2];
    cpu1_sftrst   = s[`RCC_SRC_SFT1];
    cpu2_sftrst   = s[`RCC_SRC_SFT2];
  endtask

  function automatic logic out_level(input string name);
    logic lvl;
    lvl = 1'bx;
    if (name == "sys") lvl = sys_rst_n;
    else if (name == "d1") lvl = d1_rst_n;
    else if (name == "d2") lvl = d2_rst_n;
    else if (name == "stby") lvl = stby_rst_n;
    else if (name == "nrst") lvl = nrst_out;
    else if (name == "cpu1") lvl = cpu1_rst_n;
    else if (name == "cpu2") lvl = cpu2_rst_n;
    return lvl;
  endfunction

  // earliest domain release, counted from the sys_rst_n rise
  function automatic int min_release(input string name);
    if (name == "d1") return `RCC_D1_RST_CYCLES + 1;
    if (name == "d2") return `RCC_D2_RST_CYCLES + 1;
    return 0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stim commands
  ////////////////////////////////////////////////////////////////////////////
  task automatic pulse_src(input rst_src_t src, input logic [3:0] drop_exp);
    int         n;
    int         i;
    logic [3:0] lows;
    n    = 3 + int'($urandom % 6);
    lows = '0;
    apply_src(src);
    // watch a few cycles past the pulse for the synchronizer delay
    for (i = 0; i < n + 5; i++) begin
      step();
      lows = lows | {~cpu2_rst_n, ~cpu1_rst_n, ~nrst_out, ~sys_rst_n};
      if (i == n - 1) apply_src('0);
    end
    flag_model = flag_model | src;
    if (lows !== drop_exp) begin
      flag_error($sformatf("cause %03h dropped outputs %h, expected %h", src, lows, drop_exp));
    end
  endtask

  task automatic wait_high(input string name, input int limit);
    int   n;
    logic was_low;
    n       = 0;
    was_low = (out_level(name) === 1'b0);
    while (out_level(name) !== 1'b1 && n < limit) begin
      step();
      n++;
    end
    if (out_level(name) !== 1'b1) begin
      report_failure($sformatf("%s did not rise within %0d cycles", name, limit));
    end else if (was_low && (cyc_cnt - sys_rise_cyc) < min_release(name)) begin
      flag_error($sformatf("%s rose %0d cycles after sys_rst_n, expected at least %0d",
                           name, cyc_cnt - sys_rise_cyc, min_release(name)));
    end
  endtask

  task automatic hold_level(input string name, input logic lvl, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      step();
      if (out_level(name) !== lvl) begin
        flag_error($sformatf("%s is %b, expected %b", name, out_level(name), lvl));
      end
    end
  endtask

  // wishbone classic, request held until the ack is seen
  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                           output wb_dat_t rdat);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    n        = 0;
    step();
    while (!wb_ack && n < ACK_LIMIT) begin
      step();
      n++;
    end
    if (!wb_ack) report_failure($sformatf("no wishbone ack for address %0h", adr));
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input wb_adr_t adr, input wb_dat_t data);
    wb_dat_t rdat;
    bus_cycle(1'b1, adr, data, rdat);
    if (adr == wb_adr_t'(`RCC_ADR_RSR) && data[`RCC_RMVF_BIT]) flag_model = '0;
    if (adr == wb_adr_t'(`RCC_ADR_PRSTR)) prstr_model = data[`RCC_NUM_PER-1:0];
  endtask

  // expected token is a hex value, or m to take it from the model
  task automatic read_check(input wb_adr_t adr, input string exp_tok);
    wb_dat_t rdat;
    wb_dat_t exp_val;
    exp_val = '0;
    if (exp_tok == "m") begin
      if (adr == wb_adr_t'(`RCC_ADR_RSR)) exp_val[`RCC_NUM_SRC-1:0] = flag_model;
      if (adr == wb_adr_t'(`RCC_ADR_PRSTR)) exp_val[`RCC_NUM_PER-1:0] = prstr_model;
    end else begin
      exp_val = exp_tok.atohex();
    end
    bus_cycle(1'b0, adr, '0, rdat);
    if (rdat !== exp_val) begin
      flag_error($sformatf("read of %0h gave %08h, expected %08h", adr, rdat, exp_val));
    end
    if (adr == wb_adr_t'(`RCC_ADR_PRSTR) && per_rst_n !== ~prstr_model) begin
      flag_error($sformatf("per_rst_n is %02h, expected %02h", per_rst_n, ~prstr_model));
    end
  endtask

  function automatic string get_token(input string s, inout int pos);
    int start;
    while (pos < s.len() && (s[pos] == " " || s[pos] == "\t")) pos++;
    start = pos;
    while (pos < s.len() && s[pos] != " " && s[pos] != "\t" && s[pos] != "\n"
           && s[pos] != "\r") pos++;
    if (pos == start) return "";
    return s.substr(start, pos - 1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int    fd;
    int    pos;
    int    i;
    string line, op, a1, a2, a3;
    void'($urandom(32'h9bd1ef44));
    sys_clk_pre = 1'b0;
    pwr_d1_ok   = 1'b0;
    apply_static(8'h2f);
    apply_src('0);
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    flag_model  = '0;
    prstr_model = '0;
    sys_prev    = 1'b0;
    sys_rise_cyc = 0;
    test_err    = 0;
    err_total   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;

    // everything held low through power-on reset
    test_name = "reset_values";
    for (i = 0; i < 4; i++) begin
      step();
      if ({sys_rst_n, d1_rst_n, d2_rst_n, stby_rst_n, nrst_out, cpu1_rst_n, cpu2_rst_n}
          !== 7'b0 || per_rst_n !== '0 || wb_ack !== 1'b0) begin
        flag_error("reset outputs not all low during reset");
      end
    end
    pwr_d1_ok = 1'b1;
    finish_test();

    fd = $fopen("sim/rcc_rst_stim.txt", "r");
    if (fd == 0) begin
      report_failure("could not open sim/rcc_rst_stim.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        pos = 0;
        op  = get_token(line, pos);
        a1  = get_token(line, pos);
        a2  = get_token(line, pos);
        a3  = get_token(line, pos);
        if (op.len() == 0 || op[0] == "#") continue;
        if (op == "test") begin
          finish_test();
          test_name = a1;
        end else if (op == "set") begin
          apply_static(8'(a1.atohex()));
        end else if (op == "pulse") begin
          pulse_src(rst_src_t'(a1.atohex()), 4'(a2.atohex()));
        end else if (op == "wait") begin
          wait_high(a1, a2.atoi());
        end else if (op == "hold") begin
          hold_level(a1, a2.atoi() != 0, a3.atoi());
        end else if (op == "wr") begin
          write_reg(wb_adr_t'(a1.atohex()), a2.atohex());
        end else if (op == "wrr") begin
          write_reg(wb_adr_t'(a1.atohex()), $urandom);
        end else if (op == "rd") begin
          read_check(wb_adr_t'(a1.atohex()), a2);
        end else begin
          report_failure({"unknown stim command ", op});
        end
      end
      $fclose(fd);
      finish_test();
    end

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/rcc_rst_pkg.sv
design/rcc_rst_src_sync.sv
design/rcc_sys_rst_gen.sv
design/rcc_domain_rst_seq.sv
design/rcc_rst_regs.sv
design/rcc_vcore_rst_ctrl.sv
sim/rcc_rst_tb.sv
